//--- list.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_mem_wb.sv
logic/rv_core.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

//--- logic/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// instruction memory, word address bits
`define RV_IMEM_AW 10

// data memory, word address bits
// dmem answers byte addresses below 2**(RV_DMEM_AW+2)
`define RV_DMEM_AW 10

// address of the first fetch
`define RV_RESET_PC 32'h0000_0000

// byte address of the output register
`define RV_IO_ADDR 32'h8000_0000

// addi x0,x0,0
`define RV_NOP 32'h0000_0013

`endif

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire prog_wr_t prog,
    output io_wr_t        io
);

    // stage to stage bundles
    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_wb_t     ex_wb;
    mem_req_t   mem_req;
    rf_wr_t     rf_wr;
    redirect_t  redirect;

    // hazard signals back into decode
    logic       stall;
    logic [4:0] ex_rd;
    logic       ex_reg_wen;

    // stage one, fetch half
    rv_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .prog     (prog),
        .stall    (stall),
        .redirect (redirect),
        .if_id    (if_id)
    );

    // stage one, decode half and register read
    rv_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id),
        .ex_rd      (ex_rd),
        .ex_reg_wen (ex_reg_wen),
        .redirect   (redirect),
        .rf_wr      (rf_wr),
        .stall      (stall),
        .id_ex      (id_ex)
    );

    // stage two
    rv_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .id_ex      (id_ex),
        .ex_rd      (ex_rd),
        .ex_reg_wen (ex_reg_wen),
        .redirect   (redirect),
        .mem_req    (mem_req),
        .ex_wb      (ex_wb)
    );

    // stage three
    rv_mem_wb u_mem_wb (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .ex_wb   (ex_wb),
        .rf_wr   (rf_wr),
        .io      (io)
    );

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_decode import rv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire if_id_t     if_id,
    input  wire logic [4:0] ex_rd,
    input  wire logic       ex_reg_wen,
    input  wire redirect_t  redirect,
    input  wire rf_wr_t     rf_wr,
    output logic            stall,
    output id_ex_t          id_ex
);

    logic [`RV_XLEN-1:0] rf [32];
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          funct3;
    logic                uses_rs1;
    logic                uses_rs2;
    opcode_e             opcode;
    ctrl_t               ctrl;
    id_ex_t              id_ex_d;

    // x0 is zero, a write in this same cycle wins over the array
    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic [4:0]          idx,
        input logic [`RV_XLEN-1:0] stored,
        input rf_wr_t              wr
    );
        if (idx == 5'd0) begin
            return '0;
        end else if (wr.valid && wr.rd == idx) begin
            return wr.data;
        end
        return stored;
    endfunction

    assign instr  = if_id.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];

    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = funct3;
        imm         = {{20{instr[31]}}, instr[31:20]};
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.b_is_imm = (opcode == OPC_OP_IMM);
                uses_rs2      = (opcode == OPC_OP);
                case (funct3)
                    // sub only for register form
                    3'b000: ctrl.alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                // u-type immediate
                imm           = {instr[31:12], 12'b0};
                ctrl.reg_wen  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.a_is_pc  = (opcode == OPC_AUIPC);
                ctrl.alu_op   = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                uses_rs1      = 1'b0;
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                ctrl.is_branch = 1'b1;
                uses_rs2       = 1'b1;
            end
            OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                uses_rs1     = 1'b0;
            end
            OPC_JALR: begin
                // rs1 + imm through the alu
                ctrl.is_jalr  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wen  = 1'b1;
                ctrl.wb_sel   = WB_PC4;
            end
            OPC_LOAD: begin
                ctrl.is_load  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_wen  = 1'b1;
                ctrl.wb_sel   = WB_MEM;
            end
            OPC_STORE: begin
                // s-type immediate
                imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                ctrl.is_store = 1'b1;
                ctrl.b_is_imm = 1'b1;
                uses_rs2      = 1'b1;
            end
            default: begin
                // unknown opcode behaves as a nop
                uses_rs1 = 1'b0;
            end
        endcase
    end

    assign rs1_val = read_port(rs1, rf[rs1], rf_wr);
    assign rs2_val = read_port(rs2, rf[rs2], rf_wr);

    // only execute can hold a result the array has not seen
    assign stall = if_id.valid && ex_reg_wen && ex_rd != 5'd0
                   && ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

    // registers come up zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_wr.valid && rf_wr.rd != 5'd0) begin
            rf[rf_wr.rd] <= rf_wr.data;
        end
    end

    // bubble on stall, redirect or empty fetch
    always_comb begin
        id_ex_d.valid   = if_id.valid && !stall && !redirect.valid;
        id_ex_d.pc      = if_id.pc;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.imm     = imm;
        id_ex_d.rd      = instr[11:7];
        id_ex_d.ctrl    = ctrl;
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_execute import rv_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire id_ex_t  id_ex,
    output logic [4:0]   ex_rd,
    output logic         ex_reg_wen,
    output redirect_t    redirect,
    output mem_req_t     mem_req,
    output ex_wb_t       ex_wb
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu;
    logic [`RV_XLEN-1:0] rel_target;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    logic                taken;
    logic                dmem_hit;
    logic                io_hit;
    ctrl_t               ctrl;
    ex_wb_t              ex_wb_d;

    assign ctrl = id_ex.ctrl;

    // operand muxes
    assign op_a = ctrl.a_is_pc ? id_ex.pc : id_ex.rs1_val;
    assign op_b = ctrl.b_is_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu = op_a + op_b;
            ALU_SUB:    alu = op_a - op_b;
            ALU_SLL:    alu = op_a << op_b[4:0];
            ALU_SLT:    alu = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu = op_a ^ op_b;
            ALU_SRL:    alu = op_a >> op_b[4:0];
            ALU_SRA:    alu = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu = op_a | op_b;
            ALU_AND:    alu = op_a & op_b;
            ALU_PASS_B: alu = op_b;
            default:    alu = op_a + op_b;
        endcase
    end

    // branch compare always on the register values
    assign br_eq  = (id_ex.rs1_val == id_ex.rs2_val);
    assign br_lt  = ($signed(id_ex.rs1_val) < $signed(id_ex.rs2_val));
    assign br_ltu = (id_ex.rs1_val < id_ex.rs2_val);

    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = br_eq;
            3'b001:  taken = !br_eq;
            3'b100:  taken = br_lt;
            3'b101:  taken = !br_lt;
            3'b110:  taken = br_ltu;
            3'b111:  taken = !br_ltu;
            default: taken = 1'b0;
        endcase
    end

    // pc relative target for branches and jal
    assign rel_target = id_ex.pc + id_ex.imm;

    // jalr drops bit zero of rs1 + imm
    assign redirect.valid  = id_ex.valid
                             && (ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken));
    assign redirect.target = ctrl.is_jalr ? {alu[`RV_XLEN-1:1], 1'b0} : rel_target;

    // address decode on the alu sum
    assign dmem_hit = (alu[`RV_XLEN-1:`RV_DMEM_AW+2] == '0);
    assign io_hit   = (alu == `RV_IO_ADDR);

    // other addresses get no request
    always_comb begin
        mem_req.valid = id_ex.valid
                        && (((ctrl.is_load || ctrl.is_store) && dmem_hit)
                            || (ctrl.is_store && io_hit));
        mem_req.write = ctrl.is_store;
        mem_req.is_io = io_hit;
        mem_req.addr  = alu[`RV_DMEM_AW+1:2];
        mem_req.wdata = id_ex.rs2_val;
    end

    // destination seen by the decode hazard check
    assign ex_rd      = id_ex.rd;
    assign ex_reg_wen = id_ex.valid && ctrl.reg_wen;

    always_comb begin
        ex_wb_d.valid   = id_ex.valid;
        ex_wb_d.rd      = id_ex.rd;
        ex_wb_d.reg_wen = ctrl.reg_wen;
        ex_wb_d.wb_sel  = ctrl.wb_sel;
        ex_wb_d.alu     = alu;
        ex_wb_d.pc      = id_ex.pc;
    end

    always_ff @(posedge clk) begin
        ex_wb <= ex_wb_d;
        if (rst) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_fetch import rv_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire prog_wr_t  prog,
    input  wire logic      stall,
    input  wire redirect_t redirect,
    output if_id_t         if_id
);

    // word wide instruction memory
    logic [`RV_XLEN-1:0] imem [2**`RV_IMEM_AW];

    // pc of the word currently in imem_q
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] imem_q;

    // low for the first cycle after reset
    logic                fetch_valid;

    // next fetch address, also the imem read address
    always_comb begin
        if (!fetch_valid) begin
            // first fetch reads the reset pc
            pc_next = pc;
        end else if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (stall) begin
            // re-read the same word
            pc_next = pc;
        end else begin
            pc_next = pc + `RV_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RV_RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            fetch_valid <= 1'b1;
        end
    end

    // program load only while in reset
    // synchronous read keeps imem_q in step with pc
    always_ff @(posedge clk) begin
        if (rst && prog.valid) begin
            imem[prog.addr] <= prog.data;
        end
        imem_q <= imem[pc_next[`RV_IMEM_AW+1:2]];
    end

    // wrong path word dropped when execute redirects
    always_comb begin
        if_id.valid = fetch_valid && !redirect.valid;
        if_id.pc    = pc;
        if_id.instr = if_id.valid ? imem_q : `RV_NOP;
    end

endmodule

`default_nettype wire

//--- logic/rv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_mem_wb import rv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t mem_req,
    input  wire ex_wb_t   ex_wb,
    output rf_wr_t        rf_wr,
    output io_wr_t        io
);

    logic [`RV_XLEN-1:0] dmem [2**`RV_DMEM_AW];
    logic [`RV_XLEN-1:0] dmem_q;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] wb_data;
    logic                dmem_we;
    // last request was a dmem load
    logic                load_hit;

    assign dmem_we = mem_req.valid && mem_req.write && !mem_req.is_io;

    // word memory, read data lands in the writeback cycle
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[mem_req.addr] <= mem_req.wdata;
        end
        dmem_q <= dmem[mem_req.addr];
    end

    // output strobe, one cycle per store
    always_ff @(posedge clk) begin
        io.data <= mem_req.wdata;
        if (rst) begin
            load_hit <= 1'b0;
            io.valid <= 1'b0;
        end else begin
            load_hit <= mem_req.valid && !mem_req.write;
            io.valid <= mem_req.valid && mem_req.write && mem_req.is_io;
        end
    end

    // loads that missed dmem read zero
    assign load_data = load_hit ? dmem_q : '0;

    always_comb begin
        case (ex_wb.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = ex_wb.pc + `RV_XLEN'd4;
            default: wb_data = ex_wb.alu;
        endcase
    end

    assign rf_wr.valid = ex_wb.valid && ex_wb.reg_wen;
    assign rf_wr.rd    = ex_wb.rd;
    assign rf_wr.data  = wb_data;

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // alu functions, pass_b serves lui
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_store;
        logic       reg_wen;
        wb_sel_e    wb_sel;
        // branch condition
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_IMEM_AW-1:0] addr;
        logic [`RV_XLEN-1:0]    data;
    } prog_wr_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        ctrl_t               ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

    // is_io marks a store to the output register
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic                   is_io;
        logic [`RV_DMEM_AW-1:0] addr;
        logic [`RV_XLEN-1:0]    wdata;
    } mem_req_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic                reg_wen;
        wb_sel_e             wb_sel;
        logic [`RV_XLEN-1:0] alu;
        logic [`RV_XLEN-1:0] pc;
    } ex_wb_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } rf_wr_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] data;
    } io_wr_t;

endpackage

`default_nettype wire

//--- test/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_pkg::*; (
    input wire logic      clk,
    input wire logic      rst,
    input wire io_wr_t    io,
    input wire redirect_t redirect,
    input wire id_ex_t    id_ex
);

    // pipeline still empty in the first cycle after reset is released
    io_low_after_reset: assert property (
        @(posedge clk) $fell(rst) |=> !io.valid
    ) else $error("io.valid high in the first cycle after reset was released");

    // wrong path instruction in decode must not reach execute
    redirect_squashes_decode: assert property (
        @(posedge clk) disable iff (rst) redirect.valid |=> !id_ex.valid
    ) else $error("id_ex valid in the cycle after a redirect");

    // strobed data fully known
    io_data_known: assert property (
        @(posedge clk) disable iff (rst) io.valid |-> !$isunknown(io.data)
    ) else $error("io.data has unknown bits while io.valid is high");

endmodule

bind rv_core rv_core_properties u_properties (
    .clk      (clk),
    .rst      (rst),
    .io       (io),
    .redirect (redirect),
    .id_ex    (id_ex)
);

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int NUM_TESTS  = 5;
    localparam int BODY_LEN   = 40;
    // dmem clear, body, dump sequence and padding
    localparam int MAX_LEN    = 16 + BODY_LEN + 37;
    localparam int RESET_CYC  = 8;
    localparam int WAIT_CYC   = 3 * MAX_LEN + 64;
    localparam int TEST_CYC   = MAX_LEN + RESET_CYC + WAIT_CYC;
    localparam int PERIOD     = 8;
    localparam int DMEM_BYTES = 1 << (`RV_DMEM_AW + 2);

    // program kinds
    localparam int K_RESET = 0;
    localparam int K_ALU   = 1;
    localparam int K_MEM   = 2;
    localparam int K_CTRL  = 3;
    localparam int K_DEP   = 4;

    logic        clk;
    logic        rst;
    prog_wr_t    prog;
    io_wr_t      io;

    logic [31:0] prog_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];
    logic [31:0] regs[32];
    logic [31:0] dmem_ref[1024];
    int          errors;
    int          test_errors;
    int          test_num;
    int          passed;
    int          failed;
    int          reg_hi;
    int          since_reset;

    rv_core DUT (
        .clk  (clk),
        .rst  (rst),
        .prog (prog),
        .io   (io)
    );

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // backstop in case a test never ends
    initial begin
        #(NUM_TESTS * (TEST_CYC + 8) * PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

    // io words in arrival order, none allowed around reset
    always @(posedge clk) begin
        if (io.valid) begin
            if (rst || since_reset < 2) begin
                $display("io.valid went high during reset or right after it");
                errors++;
                test_errors++;
            end else begin
                got_q.push_back(io.data);
            end
        end
        since_reset = rst ? 0 : since_reset + 1;
    end

    task automatic check_eq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // small pool in the dependence test
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(reg_hi, 1));
    endfunction

    function automatic logic [31:0] gen_alu();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        int unsigned sel;
        f3  = 3'($urandom);
        imm = 12'($urandom);
        sel = $urandom_range(9, 0);
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && sel[0]) ? 7'h20 : 7'h00;
        // shift immediates carry only shamt and the sra bit
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
            imm[11:5] = imm[10] ? 7'h20 : 7'h00;
        end
        if (sel < 4) begin
            return enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg());
        end else if (sel < 8) begin
            return enc_i(imm, pick_reg(), f3, pick_reg(), 7'h13);
        end else if (sel == 8) begin
            return enc_u(20'($urandom), pick_reg(), 7'h37);
        end
        return enc_u(20'($urandom), pick_reg(), 7'h17);
    endfunction

    // x0 based, words 0 to 15 or just below address zero
    function automatic logic [31:0] gen_mem();
        logic [11:0] off;
        off = 12'($urandom_range(15, 0) * 4);
        case ($urandom_range(3, 0))
            0: return enc_i(off, 5'd0, 3'b010, pick_reg(), 7'h03);
            1: return enc_i(-off - 12'd4, 5'd0, 3'b010, pick_reg(), 7'h03);
            2: return enc_s(off, pick_reg(), 5'd0);
            default: return enc_s(-off - 12'd4, pick_reg(), 5'd0);
        endcase
    endfunction

    // forward targets only, never past the dump sequence
    function automatic logic [31:0] gen_ctrl(input int here, input int last);
        int         target;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        target = here + $urandom_range(4, 1);
        if (target > last) begin
            target = last;
        end
        rs1 = pick_reg();
        rs2 = ($urandom_range(3, 0) == 0) ? rs1 : pick_reg();
        f3  = 3'($urandom);
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = {2'b00, f3[0]};
        end
        case ($urandom_range(3, 0))
            0: return enc_j(21'((target - here) * 4), pick_reg());
            1: return enc_i(12'(target * 4), 5'd0, 3'b000, pick_reg(), 7'h67);
            default: return enc_b(13'((target - here) * 4), rs2, rs1, f3);
        endcase
    endfunction

    task automatic build_program(input int kind, input int n);
        int start;
        int last;
        int roll;
        prog_q.delete();
        reg_hi = (kind == K_DEP) ? 4 : 31;
        // zero the dmem words the body may load
        if (kind != K_RESET) begin
            for (int k = 0; k < 16; k++) begin
                prog_q.push_back(enc_s(12'(4 * k), 5'd0, 5'd0));
            end
        end
        start = prog_q.size();
        last  = start + n;
        for (int i = start; i < last; i++) begin
            roll = $urandom_range(99, 0);
            if (kind == K_RESET) begin
                prog_q.push_back(enc_u(20'($urandom), 5'd1, 7'h37));
            end else if (kind == K_MEM && roll < 50) begin
                prog_q.push_back(gen_mem());
            end else if (kind == K_CTRL && roll < 35) begin
                prog_q.push_back(gen_ctrl(i, last));
            end else if (kind == K_DEP && roll >= 75) begin
                prog_q.push_back(gen_ctrl(i, last));
            end else if (kind == K_DEP && roll >= 50) begin
                prog_q.push_back(gen_mem());
            end else begin
                prog_q.push_back(gen_alu());
            end
        end
        // dump x1..x31, x31 parked in dmem while it holds the io base
        prog_q.push_back(enc_s(12'd128, 5'd31, 5'd0));
        prog_q.push_back(enc_u(20'(`RV_IO_ADDR >> 12), 5'd31, 7'h37));
        for (int r = 1; r < 31; r++) begin
            prog_q.push_back(enc_s(12'd0, 5'(r), 5'd31));
        end
        prog_q.push_back(enc_i(12'd128, 5'd0, 3'b010, 5'd1, 7'h03));
        prog_q.push_back(enc_s(12'd0, 5'd1, 5'd31));
        // spin in place
        prog_q.push_back(enc_j(21'd0, 5'd0));
        prog_q.push_back(`RV_NOP);
        prog_q.push_back(`RV_NOP);
    endtask

    // reference alu, alt picks sub or sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // instruction set model, fills exp_q with the io words
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        wen;
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 1024; w++) begin
            dmem_ref[w] = '0;
        end
        pc = `RV_RESET_PC;
        for (int step = 0; step < 4 * prog_q.size(); step++) begin
            ins   = prog_q[pc >> 2];
            f3    = ins[14:12];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = pc + 32'd4;
            wen   = 1'b1;
            res   = pc + 32'd4;
            case (ins[6:0])
                7'h33: res = alu_ref(f3, ins[30], a, b);
                7'h13: res = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
                7'h37: res = {ins[31:12], 12'h000};
                7'h17: res = pc + {ins[31:12], 12'h000};
                7'h6f: npc = pc + imm_j;
                7'h67: npc = (a + imm_i) & ~32'd1;
                7'h63: begin
                    wen = 1'b0;
                    if (branch_ref(f3, a, b)) begin
                        npc = pc + imm_b;
                    end
                end
                7'h03: begin
                    addr = a + imm_i;
                    res  = (addr < DMEM_BYTES) ? dmem_ref[addr[11:2]] : '0;
                end
                7'h23: begin
                    wen  = 1'b0;
                    addr = a + imm_s;
                    if (addr == `RV_IO_ADDR) begin
                        exp_q.push_back(b);
                    end else if (addr < DMEM_BYTES) begin
                        dmem_ref[addr[11:2]] = b;
                    end
                end
                default: wen = 1'b0;
            endcase
            if (wen && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            if (npc == pc) begin
                break;
            end
            pc = npc;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int waited;
        test_errors = 0;
        test_num++;
        build_program(kind, n);
        run_model();
        @(negedge clk);
        rst = 1'b1;
        got_q.delete();
        // one program word per cycle under reset
        foreach (prog_q[i]) begin
            prog.valid = 1'b1;
            prog.addr  = `RV_IMEM_AW'(i);
            prog.data  = prog_q[i];
            @(negedge clk);
        end
        prog = '0;
        repeat (RESET_CYC) @(negedge clk);
        rst    = 1'b0;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < WAIT_CYC) begin
            @(negedge clk);
            waited++;
        end
        // a few more cycles to catch stray strobes
        repeat (4) @(negedge clk);
        if (got_q.size() != exp_q.size()) begin
            $display("%s: expected %0d outputs but %0d arrived, outputs were missing or extra",
                     name, exp_q.size(), got_q.size());
            errors++;
            test_errors++;
        end
        foreach (got_q[i]) begin
            if (i < exp_q.size()) begin
                check_eq("io.data", exp_q[i], got_q[i]);
            end
        end
        if (test_errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %s, %0d outputs", test_num, name,
                 (test_errors == 0) ? "pass" : "FAIL", got_q.size());
    endtask

    initial begin
        void'($urandom(32'hda57_5cec));
        rst         = 1'b1;
        prog        = '0;
        errors      = 0;
        test_errors = 0;
        test_num    = 0;
        passed      = 0;
        failed      = 0;
        reg_hi      = 31;
        since_reset = 0;
        run_test("reset", K_RESET, 1);
        run_test("alu", K_ALU, BODY_LEN);
        run_test("load_store", K_MEM, BODY_LEN);
        run_test("control", K_CTRL, BODY_LEN);
        run_test("dependence", K_DEP, BODY_LEN);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_num, passed, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
